// ==== qsfp_defines.svh ====
/* Build constants for the four-lane QSFP port block.
   Register address splits as lane[15:14], window[13:12], offset[11:0]. */

`ifndef QSFP_DEFINES_SVH
`define QSFP_DEFINES_SVH

// Lane count and stream width
`define QSFP_NUM_LANES 4
`define QSFP_DATA_W 64

// Register port widths
`define QSFP_REG_AW 16
`define QSFP_REG_DW 32

// Window codes, code 1 is left unmapped
`define QSFP_WIN_DMA 2'd0
`define QSFP_WIN_MISC 2'd2
`define QSFP_WIN_MAC 2'd3

// Misc window byte offsets, upper address bits already cleared by the decoder
`define QSFP_REG_MODE 16'h0000
`define QSFP_REG_PORT_INFO 16'h0004
`define QSFP_REG_SCRATCH 16'h0008
`define QSFP_REG_TX_BEATS 16'h000C
`define QSFP_REG_RX_BEATS 16'h0010

// Port identity and status timing
`define QSFP_PORTNUM 8'h00
`define QSFP_ACT_HOLD 16
`define QSFP_CNT_W 16

`endif

// ==== qsfp_pkg.sv ====
/* Shared types for the QSFP port block. Sizes come from the defines header. */

`default_nettype none

`include "qsfp_defines.svh"

package qsfp_pkg;

  // Lane mode, codes 2 and 3 behave as disabled
  typedef enum logic [1:0] {
    MODE_DISABLED = 2'd0,
    MODE_PASSTHRU = 2'd1
  } lane_mode_t;

  // Register port words
  typedef logic [`QSFP_REG_AW-1:0] reg_addr_t;
  typedef logic [`QSFP_REG_DW-1:0] reg_data_t;

  // One request per cycle, at most one strobe high
  typedef struct packed {
    logic      wr_req;
    logic      rd_req;
    reg_addr_t addr;
    reg_data_t wr_data;
  } reg_req_t;

  // Read response, rd_resp is a single-cycle pulse
  typedef struct packed {
    logic      rd_resp;
    logic      rd_err;
    reg_data_t rd_data;
  } reg_resp_t;

  // Stream beat as carried on every lane direction
  typedef struct packed {
    logic [`QSFP_DATA_W-1:0] data;
    logic                    last;
  } stream_beat_t;

  // Accepted beat count, wraps at full scale
  typedef logic [`QSFP_CNT_W-1:0] lane_cnt_t;

endpackage : qsfp_pkg

`default_nettype wire

// ==== qsfp_reg_decode.sv ====
/* Routes each register request to one lane's misc window.
   DMA, MAC and window 1 reads get an error reply one cycle later. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module qsfp_reg_decode
  import qsfp_pkg::*;
(
  input  wire logic                           bus_clk,
  input  wire logic                           reset_i,
  input  wire reg_req_t                       req_i,
  output reg_req_t [`QSFP_NUM_LANES-1:0]      lane_req_o,
  output reg_resp_t                           err_resp_o
);

  localparam int OFFS_W = `QSFP_REG_AW - 4;

  logic [1:0] lane_sel;
  logic [1:0] win_sel;
  logic       misc_hit;
  logic       err_q;

  // ------------------------------------------------------------------------
  // Address split
  // ------------------------------------------------------------------------

  // Top two bits pick the lane, next two the window
  assign lane_sel = req_i.addr[`QSFP_REG_AW-1 -: 2];
  assign win_sel  = req_i.addr[`QSFP_REG_AW-3 -: 2];
  assign misc_hit = (win_sel == `QSFP_WIN_MISC);

  // Strobes only for the addressed lane, offset bits only
  always_comb begin
    for (int l = 0; l < `QSFP_NUM_LANES; l++) begin
      lane_req_o[l].wr_req  = req_i.wr_req && misc_hit && (lane_sel == l);
      lane_req_o[l].rd_req  = req_i.rd_req && misc_hit && (lane_sel == l);
      lane_req_o[l].addr    = {4'b0000, req_i.addr[OFFS_W-1:0]};
      lane_req_o[l].wr_data = req_i.wr_data;
    end
  end

  // ------------------------------------------------------------------------
  // Unmapped windows
  // ------------------------------------------------------------------------

  // Any read outside misc gets a flagged reply, writes just vanish
  always_ff @(posedge bus_clk) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.rd_req && !misc_hit;
    end
  end

  // Error reply carries zero data
  assign err_resp_o = '{rd_resp: err_q, rd_err: err_q, rd_data: '0};

endmodule : qsfp_reg_decode

`default_nettype wire

// ==== qsfp_lane_regs.sv ====
/* Misc window registers of one lane. Offsets arrive with upper bits clear.
   Read data is valid only while rd_resp is high. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module qsfp_lane_regs
  import qsfp_pkg::*;
#(
  parameter int LANE = 0
)(
  input  wire logic      bus_clk,
  input  wire logic      reset_i,
  input  wire reg_req_t  req_i,
  output reg_resp_t      resp_o,
  output lane_mode_t     mode_o,
  input  wire lane_cnt_t tx_beats_i,
  input  wire lane_cnt_t rx_beats_i,
  input  wire logic      link_up_i
);

  lane_mode_t mode_q;
  reg_data_t  scratch_q;
  reg_data_t  rd_value;
  reg_data_t  port_info;
  logic       rd_vld_q;
  reg_data_t  rd_data_q;

  // ------------------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------------------

  // Mode keeps two bits, scratch keeps the full word
  always_ff @(posedge bus_clk) begin
    if (reset_i) begin
      mode_q    <= MODE_DISABLED;
      scratch_q <= '0;
    end else if (req_i.wr_req) begin
      if (req_i.addr == `QSFP_REG_MODE) begin
        mode_q <= lane_mode_t'(req_i.wr_data[1:0]);
      end
      if (req_i.addr == `QSFP_REG_SCRATCH) begin
        scratch_q <= req_i.wr_data;
      end
    end
  end

  assign mode_o = mode_q;

  // ------------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------------

  // Port number, lane index, mode and link
  assign port_info = {`QSFP_PORTNUM, 8'(LANE), 6'b0, mode_q, 7'b0, link_up_i};

  // Readback select, unknown offsets give zero
  always_comb begin
    case (req_i.addr)
      `QSFP_REG_MODE:      rd_value = {30'b0, mode_q};
      `QSFP_REG_PORT_INFO: rd_value = port_info;
      `QSFP_REG_SCRATCH:   rd_value = scratch_q;
      `QSFP_REG_TX_BEATS:  rd_value = {{(`QSFP_REG_DW-`QSFP_CNT_W){1'b0}}, tx_beats_i};
      `QSFP_REG_RX_BEATS:  rd_value = {{(`QSFP_REG_DW-`QSFP_CNT_W){1'b0}}, rx_beats_i};
      default:             rd_value = '0;
    endcase
  end

  // Response pulse one cycle after the request
  always_ff @(posedge bus_clk) begin
    if (reset_i) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= req_i.rd_req;
    end
  end

  // Data captured with the request
  always_ff @(posedge bus_clk) begin
    if (req_i.rd_req) begin
      rd_data_q <= rd_value;
    end
  end

  // Lane registers never flag an error
  assign resp_o = '{rd_resp: rd_vld_q, rd_err: 1'b0, rd_data: rd_data_q};

endmodule : qsfp_lane_regs

`default_nettype wire

// ==== qsfp_lane_path.sv ====
/* Stream routing of one lane. Passthrough is fully combinational both ways;
   any other mode ties the lane off with valid low and ready high. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module qsfp_lane_path
  import qsfp_pkg::*;
(
  input  wire logic         bus_clk,
  input  wire logic         reset_i,
  input  wire lane_mode_t   mode_i,
  // Router to lane
  input  wire stream_beat_t v2e_i,
  input  wire logic         v2e_valid_i,
  output logic              v2e_ready_o,
  output stream_beat_t      lane_tx_o,
  output logic              lane_tx_valid_o,
  input  wire logic         lane_tx_ready_i,
  // Lane to router
  input  wire stream_beat_t lane_rx_i,
  input  wire logic         lane_rx_valid_i,
  output logic              lane_rx_ready_o,
  output stream_beat_t      e2v_o,
  output logic              e2v_valid_o,
  input  wire logic         e2v_ready_i,
  // Status
  input  wire logic         link_i,
  output logic              link_up_o,
  output logic              activity_o,
  output lane_cnt_t         tx_beats_o,
  output lane_cnt_t         rx_beats_o
);

  localparam int ACT_W = $clog2(`QSFP_ACT_HOLD + 1);

  logic             passthru;
  logic             tx_fire;
  logic             rx_fire;
  lane_cnt_t        tx_cnt_q;
  lane_cnt_t        rx_cnt_q;
  logic [ACT_W-1:0] act_cnt_q;
  logic             link_up_q;

  assign passthru = (mode_i == MODE_PASSTHRU);

  // ------------------------------------------------------------------------
  // Stream routing
  // ------------------------------------------------------------------------

  always_comb begin
    if (passthru) begin
      lane_tx_o       = v2e_i;
      lane_tx_valid_o = v2e_valid_i;
      v2e_ready_o     = lane_tx_ready_i;
      e2v_o           = lane_rx_i;
      e2v_valid_o     = lane_rx_valid_i;
      lane_rx_ready_o = e2v_ready_i;
    end else begin
      // Tied off, both sources drain freely
      lane_tx_o       = '0;
      lane_tx_valid_o = 1'b0;
      v2e_ready_o     = 1'b1;
      e2v_o           = '0;
      e2v_valid_o     = 1'b0;
      lane_rx_ready_o = 1'b1;
    end
  end

  // Accepted beats on the lane side of each direction
  assign tx_fire = lane_tx_valid_o && lane_tx_ready_i;
  assign rx_fire = e2v_valid_o && e2v_ready_i;

  // ------------------------------------------------------------------------
  // Counters and status
  // ------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (reset_i) begin
      tx_cnt_q  <= '0;
      rx_cnt_q  <= '0;
      act_cnt_q <= '0;
      link_up_q <= 1'b0;
    end else begin
      // Free-running counts, wrap at full scale
      if (tx_fire) tx_cnt_q <= tx_cnt_q + 1'b1;
      if (rx_fire) rx_cnt_q <= rx_cnt_q + 1'b1;
      // Reload on any beat, otherwise bleed down to zero
      if (tx_fire || rx_fire) begin
        act_cnt_q <= ACT_W'(`QSFP_ACT_HOLD);
      end else if (act_cnt_q != '0) begin
        act_cnt_q <= act_cnt_q - 1'b1;
      end
      link_up_q <= link_i && passthru;
    end
  end

  assign tx_beats_o = tx_cnt_q;
  assign rx_beats_o = rx_cnt_q;
  assign link_up_o  = link_up_q;
  assign activity_o = (act_cnt_q != '0);

endmodule : qsfp_lane_path

`default_nettype wire

// ==== qsfp_resp_mux.sv ====
/* Merges lane and decoder read responses into one registered reply.
   Assumes at most one responder pulses in a given cycle. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module qsfp_resp_mux
  import qsfp_pkg::*;
(
  input  wire logic                            bus_clk,
  input  wire logic                            reset_i,
  input  wire reg_resp_t [`QSFP_NUM_LANES-1:0] lane_resp_i,
  input  wire reg_resp_t                       err_resp_i,
  output reg_resp_t                            resp_o
);

  reg_resp_t merged;
  logic      resp_vld_q;
  logic      resp_err_q;
  reg_data_t resp_data_q;

  // OR tree, each source gated by its own pulse
  always_comb begin
    merged.rd_resp = err_resp_i.rd_resp;
    merged.rd_err  = err_resp_i.rd_resp && err_resp_i.rd_err;
    merged.rd_data = err_resp_i.rd_resp ? err_resp_i.rd_data : '0;
    for (int l = 0; l < `QSFP_NUM_LANES; l++) begin
      merged.rd_resp = merged.rd_resp | lane_resp_i[l].rd_resp;
      merged.rd_err  = merged.rd_err | (lane_resp_i[l].rd_resp & lane_resp_i[l].rd_err);
      merged.rd_data = merged.rd_data |
                       (lane_resp_i[l].rd_resp ? lane_resp_i[l].rd_data : '0);
    end
  end

  // Pulse and error flag
  always_ff @(posedge bus_clk) begin
    if (reset_i) begin
      resp_vld_q <= 1'b0;
      resp_err_q <= 1'b0;
    end else begin
      resp_vld_q <= merged.rd_resp;
      resp_err_q <= merged.rd_err;
    end
  end

  always_ff @(posedge bus_clk) begin
    resp_data_q <= merged.rd_data;
  end

  assign resp_o = '{rd_resp: resp_vld_q, rd_err: resp_err_q, rd_data: resp_data_q};

endmodule : qsfp_resp_mux

`default_nettype wire

// ==== qsfp_port.sv ====
/* Four-lane QSFP port, all in bus_clk. Reads answer two cycles after rd_req.
   Lane modes are runtime registers and start disabled. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module qsfp_port
  import qsfp_pkg::*;
(
  input  wire logic                               bus_clk,
  input  wire logic                               reset_i,
  // Register port
  input  wire reg_req_t                           reg_req_i,
  output reg_resp_t                               reg_resp_o,
  // Router side
  input  wire stream_beat_t [`QSFP_NUM_LANES-1:0] v2e_i,
  input  wire logic [`QSFP_NUM_LANES-1:0]         v2e_valid_i,
  output logic [`QSFP_NUM_LANES-1:0]              v2e_ready_o,
  output stream_beat_t [`QSFP_NUM_LANES-1:0]      e2v_o,
  output logic [`QSFP_NUM_LANES-1:0]              e2v_valid_o,
  input  wire logic [`QSFP_NUM_LANES-1:0]         e2v_ready_i,
  // Serial side
  output stream_beat_t [`QSFP_NUM_LANES-1:0]      lane_tx_o,
  output logic [`QSFP_NUM_LANES-1:0]              lane_tx_valid_o,
  input  wire logic [`QSFP_NUM_LANES-1:0]         lane_tx_ready_i,
  input  wire stream_beat_t [`QSFP_NUM_LANES-1:0] lane_rx_i,
  input  wire logic [`QSFP_NUM_LANES-1:0]         lane_rx_valid_i,
  output logic [`QSFP_NUM_LANES-1:0]              lane_rx_ready_o,
  // Status
  input  wire logic [`QSFP_NUM_LANES-1:0]         link_i,
  output logic [`QSFP_NUM_LANES-1:0]              link_up_o,
  output logic [`QSFP_NUM_LANES-1:0]              activity_o
);

  reg_req_t   [`QSFP_NUM_LANES-1:0] lane_req;
  reg_resp_t  [`QSFP_NUM_LANES-1:0] lane_resp;
  reg_resp_t                        err_resp;
  lane_mode_t [`QSFP_NUM_LANES-1:0] lane_mode;
  lane_cnt_t  [`QSFP_NUM_LANES-1:0] tx_beats;
  lane_cnt_t  [`QSFP_NUM_LANES-1:0] rx_beats;

  // ------------------------------------------------------------------------
  // Register decode and response merge
  // ------------------------------------------------------------------------

  qsfp_reg_decode qsfp_reg_decode_i (
    .bus_clk    (bus_clk),
    .reset_i    (reset_i),
    .req_i      (reg_req_i),
    .lane_req_o (lane_req),
    .err_resp_o (err_resp)
  );

  qsfp_resp_mux qsfp_resp_mux_i (
    .bus_clk     (bus_clk),
    .reset_i     (reset_i),
    .lane_resp_i (lane_resp),
    .err_resp_i  (err_resp),
    .resp_o      (reg_resp_o)
  );

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------

  for (genvar l = 0; l < `QSFP_NUM_LANES; l++) begin : g_lane

    // Misc window of this lane
    qsfp_lane_regs #(
      .LANE (l)
    ) qsfp_lane_regs_i (
      .bus_clk    (bus_clk),
      .reset_i    (reset_i),
      .req_i      (lane_req[l]),
      .resp_o     (lane_resp[l]),
      .mode_o     (lane_mode[l]),
      .tx_beats_i (tx_beats[l]),
      .rx_beats_i (rx_beats[l]),
      .link_up_i  (link_up_o[l])
    );

    // Datapath and status
    qsfp_lane_path qsfp_lane_path_i (
      .bus_clk         (bus_clk),
      .reset_i         (reset_i),
      .mode_i          (lane_mode[l]),
      .v2e_i           (v2e_i[l]),
      .v2e_valid_i     (v2e_valid_i[l]),
      .v2e_ready_o     (v2e_ready_o[l]),
      .lane_tx_o       (lane_tx_o[l]),
      .lane_tx_valid_o (lane_tx_valid_o[l]),
      .lane_tx_ready_i (lane_tx_ready_i[l]),
      .lane_rx_i       (lane_rx_i[l]),
      .lane_rx_valid_i (lane_rx_valid_i[l]),
      .lane_rx_ready_o (lane_rx_ready_o[l]),
      .e2v_o           (e2v_o[l]),
      .e2v_valid_o     (e2v_valid_o[l]),
      .e2v_ready_i     (e2v_ready_i[l]),
      .link_i          (link_i[l]),
      .link_up_o       (link_up_o[l]),
      .activity_o      (activity_o[l]),
      .tx_beats_o      (tx_beats[l]),
      .rx_beats_o      (rx_beats[l])
    );

  end : g_lane

endmodule : qsfp_port

`default_nettype wire

// ==== tb_qsfp_port.sv ====
/* Self-checking testbench for the QSFP port block. Inputs change on the
   falling edge and a model checks every output on the rising edge. */

`timescale 1ns/10ps
`default_nettype none

`include "qsfp_defines.svh"

module tb_qsfp_port
  import qsfp_pkg::*;
();

  localparam int NL = `QSFP_NUM_LANES;
  localparam int TIME_LIMIT_NS = 2_000_000;
  localparam logic [1:0] MISC = `QSFP_WIN_MISC;

  logic                  bus_clk;
  logic                  reset_i;
  reg_req_t              reg_req_i;
  reg_resp_t             reg_resp_o;
  stream_beat_t [NL-1:0] v2e_i, e2v_o, lane_tx_o, lane_rx_i;
  logic [NL-1:0]         v2e_valid_i, v2e_ready_o, e2v_valid_o, e2v_ready_i;
  logic [NL-1:0]         lane_tx_valid_o, lane_tx_ready_i, lane_rx_valid_i, lane_rx_ready_o;
  logic [NL-1:0]         link_i, link_up_o, activity_o;

  // Model state updated on each rising edge
  logic [1:0]   mode_m    [NL];
  reg_data_t    scratch_m [NL];
  lane_cnt_t    tx_cnt_m  [NL];
  lane_cnt_t    rx_cnt_m  [NL];
  logic         link_m    [NL];
  int           act_m     [NL];
  // Beats seen leaving the DUT
  int           tx_total  [NL];
  int           rx_total  [NL];
  logic         v2e_took  [NL];
  logic         rx_took   [NL];
  stream_beat_t tx_q      [NL][$];
  stream_beat_t rx_q      [NL][$];
  reg_resp_t    exp_pipe  [2];
  // Reads sampled on the port and responses seen from the DUT
  int           rd_issued;
  int           rd_seen;
  int           errors;
  int           checks;
  string        test_name;

  qsfp_port dut_i (.*);

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  // Hard stop in case a phase never finishes
  initial begin
    #(TIME_LIMIT_NS);
    $display("Run time limit reached before the test sequence finished");
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Checks and model helpers
  // ------------------------------------------------------------------------

  task automatic compare_value(input string what, input logic [64:0] expv,
                               input logic [64:0] actv);
    checks++;
    assert (actv === expv) else begin
      errors++;
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, expv, actv);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Failure in %s: %s", test_name, msg);
  endtask

  function automatic reg_addr_t lane_addr(input int lane, input logic [1:0] win,
                                          input logic [15:0] offs);
    return {2'(lane), win, offs[11:0]};
  endfunction

  // Error flag in bit 32 above the read data
  function automatic logic [32:0] model_read(input reg_addr_t addr);
    int          lane;
    logic [15:0] offs;
    lane = int'(addr[15:14]);
    offs = {4'b0000, addr[11:0]};
    if (addr[13:12] != MISC) return {1'b1, 32'h0};
    case (offs)
      `QSFP_REG_MODE:      return {1'b0, 30'h0, mode_m[lane]};
      `QSFP_REG_PORT_INFO: return {1'b0, `QSFP_PORTNUM, 8'(lane), 6'h0, mode_m[lane],
                                   7'h0, link_m[lane]};
      `QSFP_REG_SCRATCH:   return {1'b0, scratch_m[lane]};
      `QSFP_REG_TX_BEATS:  return {1'b0, 16'h0, tx_cnt_m[lane]};
      `QSFP_REG_RX_BEATS:  return {1'b0, 16'h0, rx_cnt_m[lane]};
      default:             return 33'h0;
    endcase
  endfunction

  // Writes outside misc are dropped
  function automatic void model_write(input reg_addr_t addr, input reg_data_t data);
    int          lane;
    logic [15:0] offs;
    lane = int'(addr[15:14]);
    offs = {4'b0000, addr[11:0]};
    if (addr[13:12] == MISC) begin
      if (offs == `QSFP_REG_MODE) mode_m[lane] = data[1:0];
      if (offs == `QSFP_REG_SCRATCH) scratch_m[lane] = data;
    end
  endfunction

  function automatic stream_beat_t random_beat();
    return '{data: {$urandom, $urandom}, last: 1'($urandom)};
  endfunction

  // ------------------------------------------------------------------------
  // Rising edge monitor
  // ------------------------------------------------------------------------

  always @(posedge bus_clk) begin
    logic [32:0]  rd_model;
    stream_beat_t beat;
    logic         pass;
    logic         tx_fire;
    logic         rx_fire;
    if (reset_i) begin
      exp_pipe[0] = '0;
      exp_pipe[1] = '0;
      rd_issued = 0;
      rd_seen = 0;
      for (int l = 0; l < NL; l++) begin
        mode_m[l] = 2'd0;
        scratch_m[l] = '0;
        tx_cnt_m[l] = '0;
        rx_cnt_m[l] = '0;
        link_m[l] = 1'b0;
        act_m[l] = 0;
        tx_total[l] = 0;
        rx_total[l] = 0;
        v2e_took[l] = 1'b0;
        rx_took[l] = 1'b0;
        tx_q[l].delete();
        rx_q[l].delete();
      end
    end else begin
      // Response due two cycles after its request
      compare_value("rd_resp", 65'(exp_pipe[1].rd_resp), 65'(reg_resp_o.rd_resp));
      if (exp_pipe[1].rd_resp) begin
        compare_value("rd_err", 65'(exp_pipe[1].rd_err), 65'(reg_resp_o.rd_err));
        compare_value("rd_data", 65'(exp_pipe[1].rd_data), 65'(reg_resp_o.rd_data));
      end
      if (reg_resp_o.rd_resp) rd_seen++;
      exp_pipe[1] = exp_pipe[0];
      exp_pipe[0] = '0;
      if (reg_req_i.rd_req) begin
        rd_issued++;
        rd_model = model_read(reg_req_i.addr);
        exp_pipe[0] = '{rd_resp: 1'b1, rd_err: rd_model[32], rd_data: rd_model[31:0]};
      end
      for (int l = 0; l < NL; l++) begin
        pass = (mode_m[l] == MODE_PASSTHRU);
        compare_value("link_up_o", 65'(link_m[l]), 65'(link_up_o[l]));
        compare_value("activity_o", 65'(act_m[l] != 0), 65'(activity_o[l]));
        // Handshake expected from mode and inputs alone
        compare_value("lane_tx_valid_o", 65'(pass && v2e_valid_i[l]), 65'(lane_tx_valid_o[l]));
        compare_value("v2e_ready_o", 65'(!pass || lane_tx_ready_i[l]), 65'(v2e_ready_o[l]));
        compare_value("e2v_valid_o", 65'(pass && lane_rx_valid_i[l]), 65'(e2v_valid_o[l]));
        compare_value("lane_rx_ready_o", 65'(!pass || e2v_ready_i[l]), 65'(lane_rx_ready_o[l]));
        tx_fire = pass && v2e_valid_i[l] && lane_tx_ready_i[l];
        rx_fire = pass && lane_rx_valid_i[l] && e2v_ready_i[l];
        if (tx_fire) tx_q[l].push_back(v2e_i[l]);
        if (rx_fire) rx_q[l].push_back(lane_rx_i[l]);
        // Beats must leave in order and unchanged
        if (lane_tx_valid_o[l] && lane_tx_ready_i[l]) begin
          tx_total[l]++;
          assert (tx_q[l].size() != 0) else report_failure("beat on lane_tx_o was never sent");
          if (tx_q[l].size() != 0) begin
            beat = tx_q[l].pop_front();
            compare_value("lane_tx_o beat", beat, lane_tx_o[l]);
          end
        end
        if (e2v_valid_o[l] && e2v_ready_i[l]) begin
          rx_total[l]++;
          assert (rx_q[l].size() != 0) else report_failure("beat on e2v_o was never sent");
          if (rx_q[l].size() != 0) begin
            beat = rx_q[l].pop_front();
            compare_value("e2v_o beat", beat, e2v_o[l]);
          end
        end
        v2e_took[l] = v2e_valid_i[l] && (!pass || lane_tx_ready_i[l]);
        rx_took[l] = lane_rx_valid_i[l] && (!pass || e2v_ready_i[l]);
        if (tx_fire) begin
          tx_cnt_m[l] = tx_cnt_m[l] + 1'b1;
        end
        if (rx_fire) begin
          rx_cnt_m[l] = rx_cnt_m[l] + 1'b1;
        end
        // Activity hold and link follow the mode before this edge's write
        if (tx_fire || rx_fire) act_m[l] = `QSFP_ACT_HOLD;
        else if (act_m[l] != 0) act_m[l]--;
        link_m[l] = link_i[l] && pass;
      end
      if (reg_req_i.wr_req) model_write(reg_req_i.addr, reg_req_i.wr_data);
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus tasks driving on the falling edge
  // ------------------------------------------------------------------------

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge bus_clk);
    reg_req_i = '{wr_req: 1'b1, rd_req: 1'b0, addr: addr, wr_data: data};
  endtask

  task automatic bus_read(input reg_addr_t addr);
    @(negedge bus_clk);
    reg_req_i = '{wr_req: 1'b0, rd_req: 1'b1, addr: addr, wr_data: '0};
  endtask

  task automatic bus_idle();
    @(negedge bus_clk);
    reg_req_i = '0;
  endtask

  task automatic wait_reads_done();
    int cycles;
    cycles = 0;
    while (rd_seen != rd_issued && cycles < 10) begin
      @(negedge bus_clk);
      cycles++;
    end
    assert (rd_seen == rd_issued) else
      report_failure("read responses still missing after 10 cycles");
  endtask

  // Random beats and back-pressure until each passthrough lane moves target beats
  task automatic run_traffic(input int target, input int limit);
    int cycles;
    bit done;
    int tx_start [NL];
    int rx_start [NL];
    for (int l = 0; l < NL; l++) begin
      tx_start[l] = tx_total[l];
      rx_start[l] = rx_total[l];
    end
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < limit) begin
      @(negedge bus_clk);
      cycles++;
      link_i = NL'($urandom);
      for (int l = 0; l < NL; l++) begin
        // Sources hold a beat until it is taken
        if (!v2e_valid_i[l] || v2e_took[l]) begin
          v2e_valid_i[l] = ($urandom % 4) != 0;
          v2e_i[l] = random_beat();
        end
        if (!lane_rx_valid_i[l] || rx_took[l]) begin
          lane_rx_valid_i[l] = ($urandom % 4) != 0;
          lane_rx_i[l] = random_beat();
        end
        lane_tx_ready_i[l] = ($urandom % 3) != 0;
        e2v_ready_i[l] = ($urandom % 3) != 0;
      end
      done = 1'b1;
      for (int l = 0; l < NL; l++) begin
        if (mode_m[l] == MODE_PASSTHRU &&
            (tx_total[l] - tx_start[l] < target || rx_total[l] - rx_start[l] < target)) begin
          done = 1'b0;
        end
      end
    end
    assert (done) else report_failure("stream traffic did not reach the beat target in time");
    @(negedge bus_clk);
    v2e_valid_i = '0;
    lane_rx_valid_i = '0;
  endtask

  task automatic wait_activity_low();
    int cycles;
    cycles = 0;
    while (activity_o != '0 && cycles < 4 * `QSFP_ACT_HOLD) begin
      @(negedge bus_clk);
      cycles++;
    end
    assert (activity_o == '0) else report_failure("activity stayed high with no beats");
  endtask

  task automatic read_counters(input int lane);
    bus_read(lane_addr(lane, MISC, `QSFP_REG_TX_BEATS));
    bus_read(lane_addr(lane, MISC, `QSFP_REG_RX_BEATS));
    bus_read(lane_addr(lane, MISC, `QSFP_REG_PORT_INFO));
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h8a16));
    errors = 0;
    checks = 0;
    test_name = "reset";
    reg_req_i = '0;
    v2e_i = '0;
    v2e_valid_i = '0;
    e2v_ready_i = '0;
    lane_tx_ready_i = '0;
    lane_rx_i = '0;
    lane_rx_valid_i = '0;
    link_i = '0;
    reset_i = 1'b1;
    repeat (2) @(posedge bus_clk);
    @(negedge bus_clk);
    reset_i = 1'b0;

    // Idle lanes show the tie-off values
    test_name = "after_reset";
    bus_idle();
    compare_value("readies after reset", 65'({v2e_ready_o, lane_rx_ready_o}),
                  65'({(2 * NL){1'b1}}));
    compare_value("valids after reset", 65'({lane_tx_valid_o, e2v_valid_o}), 65'(0));
    bus_idle();

    test_name = "reg_round_trip";
    for (int l = 0; l < NL; l++) begin
      bus_write(lane_addr(l, MISC, `QSFP_REG_MODE), $urandom);
      bus_write(lane_addr(l, MISC, `QSFP_REG_SCRATCH), $urandom);
    end
    // Back-to-back reads across all lanes
    for (int l = 0; l < NL; l++) begin
      bus_read(lane_addr(l, MISC, `QSFP_REG_MODE));
      bus_read(lane_addr(l, MISC, `QSFP_REG_SCRATCH));
      bus_read(lane_addr(l, MISC, `QSFP_REG_PORT_INFO));
      bus_read(lane_addr(l, MISC, 16'h0014));
    end
    bus_idle();
    wait_reads_done();

    test_name = "windows";
    for (int l = 0; l < NL; l++) begin
      for (int w = 0; w < 4; w++) begin
        if (w != int'(MISC)) begin
          bus_write(lane_addr(l, 2'(w), `QSFP_REG_SCRATCH), $urandom);
          bus_write(lane_addr(l, 2'(w), `QSFP_REG_MODE), 32'h1);
          bus_read(lane_addr(l, 2'(w), `QSFP_REG_SCRATCH));
          bus_read(lane_addr(l, 2'(w), `QSFP_REG_MODE));
        end
      end
      bus_read(lane_addr(l, MISC, `QSFP_REG_SCRATCH));
      bus_read(lane_addr(l, MISC, `QSFP_REG_MODE));
    end
    bus_idle();
    wait_reads_done();

    // Lanes 0 and 2 pass while lane 1 is off and lane 3 has an undefined code
    test_name = "passthrough";
    bus_write(lane_addr(0, MISC, `QSFP_REG_MODE), 32'h1);
    bus_write(lane_addr(1, MISC, `QSFP_REG_MODE), 32'h0);
    bus_write(lane_addr(2, MISC, `QSFP_REG_MODE), 32'h1);
    bus_write(lane_addr(3, MISC, `QSFP_REG_MODE), 32'h3);
    bus_idle();
    run_traffic(40, 2000);
    for (int l = 0; l < NL; l++) read_counters(l);
    bus_idle();
    wait_reads_done();

    // Single beat on lane 1 and then the hold runs out
    test_name = "activity";
    wait_activity_low();
    bus_write(lane_addr(1, MISC, `QSFP_REG_MODE), 32'h1);
    bus_idle();
    v2e_valid_i[1] = 1'b1;
    v2e_i[1] = random_beat();
    lane_tx_ready_i[1] = 1'b1;
    @(negedge bus_clk);
    v2e_valid_i[1] = 1'b0;
    wait_activity_low();

    test_name = "disable_lane";
    bus_write(lane_addr(0, MISC, `QSFP_REG_MODE), 32'h0);
    bus_idle();
    run_traffic(20, 2000);
    read_counters(0);
    read_counters(3);
    bus_idle();
    wait_reads_done();
    wait_activity_low();

    @(negedge bus_clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_qsfp_port

`default_nettype wire

// ==== verilog.f ====
+incdir+.
qsfp_pkg.sv
qsfp_reg_decode.sv
qsfp_lane_regs.sv
qsfp_lane_path.sv
qsfp_resp_mux.sv
qsfp_port.sv
tb_qsfp_port.sv

// ==== Makefile ====
# Verilator build and run for the QSFP port testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_qsfp_port
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(EXE): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) qsfp_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST) -o V$(TOP)

test: $(EXE)
	./$(EXE) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
